/* src/xaui_regs_pkg.sv */
// management bus and register map
`default_nettype none

package xaui_regs_pkg;

  ////////////////////////////////////////////////////////////
  // bus structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [7:0]  address;   // word address
    logic        read;
    logic        write;
    logic [31:0] writedata;
  } mgmt_req_t;

  typedef struct packed {
    logic [31:0] readdata;    // registered, valid when waitrequest low
    logic        waitrequest;
  } mgmt_rsp_t;

  typedef struct packed {
    logic [5:0]  offset;    // offset inside one region
    logic        read;      // already gated by region
    logic        write;
    logic [31:0] writedata;
  } slave_req_t;

  ////////////////////////////////////////////////////////////
  // regions and offsets
  ////////////////////////////////////////////////////////////
  localparam logic [7:0] chan_base = 8'h40;  // 0x40..0x7f
  localparam logic [7:0] pcs_base  = 8'h80;  // 0x80..0x9f

  localparam logic [5:0] off_pll_locked      = 6'd1;   // ro
  localparam logic [5:0] off_reset_ctrl      = 6'd2;   // wr pulses, rd ready flags
  localparam logic [5:0] off_pll_powerdown   = 6'd4;
  localparam logic [5:0] off_tx_digitalreset = 6'd5;
  localparam logic [5:0] off_rx_analogreset  = 6'd6;
  localparam logic [5:0] off_rx_digitalreset = 6'd7;
  localparam logic [5:0] off_loopback        = 6'd8;
  localparam logic [5:0] off_locktoref       = 6'd9;
  localparam logic [5:0] off_locktodata      = 6'd10;
  localparam logic [5:0] off_lockedtodata    = 6'd11;  // ro

  localparam logic [5:0] off_pcs_reset  = 6'd0;  // bit0 tx, bit1 rx
  localparam logic [5:0] off_syncstatus = 6'd1;  // live
  localparam logic [5:0] off_errdetect  = 6'd2;  // sticky, w1c
  localparam logic [5:0] off_disperr    = 6'd3;  // sticky, w1c

  localparam logic [31:0] unmapped_data = 32'hffff_ffff;

endpackage

`default_nettype wire

/* src/xaui_lane_pkg.sv */
// lane status and reset types
`default_nettype none

package xaui_lane_pkg;

  localparam int lanes = 4;  // fixed by xaui

  typedef struct packed {
    logic             pll_locked;
    logic             pll_cal_busy;
    logic [lanes-1:0] tx_cal_busy;
    logic [lanes-1:0] rx_cal_busy;
    logic [lanes-1:0] rx_is_lockedtodata;
  } lane_status_t;

  typedef struct packed {
    logic [2*lanes-1:0] rx_syncstatus;  // two bytes per lane
    logic [2*lanes-1:0] rx_errdetect;
    logic [2*lanes-1:0] rx_disperr;
  } pcs_status_t;

  typedef struct packed {
    logic             reset_all;         // strobe
    logic             reset_tx_digital;  // strobe
    logic             reset_rx_digital;  // strobe
    logic             pll_powerdown;
    logic [lanes-1:0] tx_digitalreset;   // per lane overrides
    logic [lanes-1:0] rx_analogreset;
    logic [lanes-1:0] rx_digitalreset;
    logic [lanes-1:0] loopback_serial;
    logic [lanes-1:0] set_locktoref;
    logic [lanes-1:0] set_locktodata;
  } csr_ctrl_t;

  typedef struct packed {
    logic             pll_powerdown;
    logic [lanes-1:0] tx_digitalreset;
    logic [lanes-1:0] rx_analogreset;
    logic [lanes-1:0] rx_digitalreset;
  } reset_out_t;

endpackage

`default_nettype wire

/* src/mgmt_decoder.sv */
// management port region decoder
`default_nettype none

module mgmt_decoder (
  input  wire logic                     phy_mgmt_clk,
  input  wire logic                     embedded_reset,
  input  wire xaui_regs_pkg::mgmt_req_t mgmt_req,
  input  wire logic [31:0]              chan_readdata,
  input  wire logic [31:0]              pcs_readdata,
  output xaui_regs_pkg::mgmt_rsp_t      mgmt_rsp,
  output xaui_regs_pkg::slave_req_t     chan_req,
  output xaui_regs_pkg::slave_req_t     pcs_req
);

  logic        chan_hit;    // 0x40..0x7f
  logic        pcs_hit;     // 0x80..0x9f
  logic        served;      // read answered this cycle
  logic        read_start;  // first cycle of a read
  logic [31:0] sel_data;
  logic [31:0] readdata_q;

  assign chan_hit   = (mgmt_req.address & 8'hc0) == xaui_regs_pkg::chan_base;
  assign pcs_hit    = (mgmt_req.address & 8'he0) == xaui_regs_pkg::pcs_base;
  assign read_start = mgmt_req.read & ~served;

  always_comb begin
    chan_req.offset    = mgmt_req.address[5:0];
    chan_req.read      = mgmt_req.read & chan_hit;
    chan_req.write     = mgmt_req.write & chan_hit;  // unmapped writes dropped
    chan_req.writedata = mgmt_req.writedata;
    pcs_req.offset     = {1'b0, mgmt_req.address[4:0]};
    pcs_req.read       = mgmt_req.read & pcs_hit;
    pcs_req.write      = mgmt_req.write & pcs_hit;
    pcs_req.writedata  = mgmt_req.writedata;
  end

  always_comb begin
    if (chan_hit) begin
      sel_data = chan_readdata;
    end else if (pcs_hit) begin
      sel_data = pcs_readdata;
    end else begin
      sel_data = xaui_regs_pkg::unmapped_data;  // all ones
    end
  end

  always_ff @(posedge phy_mgmt_clk) begin
    if (embedded_reset) begin
      served <= 1'b0;
    end else begin
      served <= read_start;  // high for the second read cycle only
    end
  end

  always_ff @(posedge phy_mgmt_clk) begin
    if (read_start) begin
      readdata_q <= sel_data;  // captured in the wait cycle
    end
  end

  assign mgmt_rsp.readdata    = readdata_q;
  assign mgmt_rsp.waitrequest = read_start;  // writes never wait

endmodule

`default_nettype wire

/* src/chan_csr.sv */
// channel and pll control registers
`default_nettype none

module chan_csr (
  input  wire logic                        phy_mgmt_clk,
  input  wire logic                        embedded_reset,
  input  wire xaui_regs_pkg::slave_req_t   req,
  input  wire xaui_lane_pkg::lane_status_t lane_status,
  input  wire logic                        tx_ready,
  input  wire logic                        rx_ready,
  output logic [31:0]                      readdata,
  output xaui_lane_pkg::csr_ctrl_t         ctrl
);

  localparam int lanes = xaui_lane_pkg::lanes;

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk) begin
    if (embedded_reset) begin
      ctrl <= '0;
    end else begin
      ctrl.reset_all        <= 1'b0;  // strobes last one cycle
      ctrl.reset_tx_digital <= 1'b0;
      ctrl.reset_rx_digital <= 1'b0;
      if (req.write) begin
        case (req.offset)
          xaui_regs_pkg::off_reset_ctrl: begin
            ctrl.reset_all        <= req.writedata[0];
            ctrl.reset_tx_digital <= req.writedata[1];
            ctrl.reset_rx_digital <= req.writedata[2];
          end
          xaui_regs_pkg::off_pll_powerdown: begin
            ctrl.pll_powerdown <= req.writedata[0];
          end
          xaui_regs_pkg::off_tx_digitalreset: begin
            ctrl.tx_digitalreset <= req.writedata[lanes-1:0];
          end
          xaui_regs_pkg::off_rx_analogreset: begin
            ctrl.rx_analogreset <= req.writedata[lanes-1:0];
          end
          xaui_regs_pkg::off_rx_digitalreset: begin
            ctrl.rx_digitalreset <= req.writedata[lanes-1:0];
          end
          xaui_regs_pkg::off_loopback: begin
            ctrl.loopback_serial <= req.writedata[lanes-1:0];  // serial loopback
          end
          xaui_regs_pkg::off_locktoref: begin
            ctrl.set_locktoref <= req.writedata[lanes-1:0];
          end
          xaui_regs_pkg::off_locktodata: begin
            ctrl.set_locktodata <= req.writedata[lanes-1:0];
          end
          default: ;  // read-only or hole
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////
  always_comb begin
    readdata = '0;  // holes read zero
    if (req.read) begin
      case (req.offset)
        xaui_regs_pkg::off_pll_locked:      readdata[0] = lane_status.pll_locked;
        xaui_regs_pkg::off_reset_ctrl:      readdata[1:0] = {rx_ready, tx_ready};
        xaui_regs_pkg::off_pll_powerdown:   readdata[0] = ctrl.pll_powerdown;
        xaui_regs_pkg::off_tx_digitalreset: readdata[lanes-1:0] = ctrl.tx_digitalreset;
        xaui_regs_pkg::off_rx_analogreset:  readdata[lanes-1:0] = ctrl.rx_analogreset;
        xaui_regs_pkg::off_rx_digitalreset: readdata[lanes-1:0] = ctrl.rx_digitalreset;
        xaui_regs_pkg::off_loopback:        readdata[lanes-1:0] = ctrl.loopback_serial;
        xaui_regs_pkg::off_locktoref:       readdata[lanes-1:0] = ctrl.set_locktoref;
        xaui_regs_pkg::off_locktodata:      readdata[lanes-1:0] = ctrl.set_locktodata;
        xaui_regs_pkg::off_lockedtodata: begin
          readdata[lanes-1:0] = lane_status.rx_is_lockedtodata;  // live cdr lock
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/pcs_csr.sv */
// pcs status and soft reset registers
`default_nettype none

module pcs_csr (
  input  wire logic                       phy_mgmt_clk,
  input  wire logic                       embedded_reset,
  input  wire xaui_regs_pkg::slave_req_t  req,
  input  wire xaui_lane_pkg::pcs_status_t pcs_status,
  output logic [31:0]                     readdata,
  output logic                            r_tx_digitalreset,
  output logic                            r_rx_digitalreset
);

  localparam int w = 2 * xaui_lane_pkg::lanes;  // status bits per field

  logic [w-1:0] errdetect_q;  // sticky
  logic [w-1:0] disperr_q;    // sticky
  logic [w-1:0] errdetect_clr;
  logic [w-1:0] disperr_clr;

  // write 1 to clear, only for the addressed register
  assign errdetect_clr = (req.write && req.offset == xaui_regs_pkg::off_errdetect) ?
                         req.writedata[w-1:0] : '0;
  assign disperr_clr   = (req.write && req.offset == xaui_regs_pkg::off_disperr) ?
                         req.writedata[w-1:0] : '0;

  always_ff @(posedge phy_mgmt_clk) begin
    if (embedded_reset) begin
      r_tx_digitalreset <= 1'b0;
      r_rx_digitalreset <= 1'b0;
      errdetect_q       <= '0;
      disperr_q         <= '0;
    end else begin
      if (req.write && req.offset == xaui_regs_pkg::off_pcs_reset) begin
        r_tx_digitalreset <= req.writedata[0];  // soft pcs tx
        r_rx_digitalreset <= req.writedata[1];  // soft pcs rx
      end
      errdetect_q <= (errdetect_q & ~errdetect_clr) | pcs_status.rx_errdetect;  // set wins
      disperr_q   <= (disperr_q & ~disperr_clr) | pcs_status.rx_disperr;
    end
  end

  always_comb begin
    readdata = '0;
    if (req.read) begin
      case (req.offset)
        xaui_regs_pkg::off_pcs_reset:  readdata[1:0] = {r_rx_digitalreset, r_tx_digitalreset};
        xaui_regs_pkg::off_syncstatus: readdata[w-1:0] = pcs_status.rx_syncstatus;  // live
        xaui_regs_pkg::off_errdetect:  readdata[w-1:0] = errdetect_q;
        xaui_regs_pkg::off_disperr:    readdata[w-1:0] = disperr_q;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/reset_sequencer.sv */
// embedded transceiver reset sequencer
`default_nettype none

module reset_sequencer #(
  parameter int t_pll_powerdown   = 100,
  parameter int t_rx_analogreset  = 8,
  parameter int t_rx_digitalreset = 400
) (
  input  wire logic                        phy_mgmt_clk,
  input  wire logic                        embedded_reset,
  input  wire xaui_lane_pkg::csr_ctrl_t    ctrl,
  input  wire xaui_lane_pkg::lane_status_t lane_status,
  output xaui_lane_pkg::reset_out_t        resets,
  output logic                             tx_ready,
  output logic                             rx_ready
);

  localparam int lanes = xaui_lane_pkg::lanes;
  localparam int t_ab  = (t_pll_powerdown > t_rx_analogreset) ?
                         t_pll_powerdown : t_rx_analogreset;
  localparam int t_max = (t_ab > t_rx_digitalreset) ? t_ab : t_rx_digitalreset;
  localparam int tw    = $clog2(t_max + 1);

  typedef enum logic [1:0] {
    st_pll_pd,
    st_tx_wait,
    st_tx_ready
  } tx_state_t;

  typedef enum logic [1:0] {
    st_rx_idle,     // waiting for pll powerdown to end
    st_rx_analog,
    st_rx_digital,
    st_rx_ready
  } rx_state_t;

  tx_state_t tx_state;
  rx_state_t rx_state;
  logic [tw-1:0] timer;  // shared, phases never overlap
  logic pll_done;
  logic tx_busy;
  logic rx_busy;
  logic all_locked;
  logic rx_manual;

  assign pll_done   = (tx_state == st_pll_pd) && (timer == tw'(t_pll_powerdown - 1));
  assign tx_busy    = lane_status.pll_cal_busy | (|lane_status.tx_cal_busy);
  assign rx_busy    = |lane_status.rx_cal_busy;
  assign all_locked = &lane_status.rx_is_lockedtodata;
  assign rx_manual  = |(ctrl.set_locktoref | ctrl.set_locktodata);  // any lock override

  ////////////////////////////////////////////////////////////
  // pll/tx and rx state machines
  ////////////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk) begin
    if (embedded_reset || ctrl.reset_all) begin
      tx_state <= st_pll_pd;  // full restart
      rx_state <= st_rx_idle;
      timer    <= '0;
    end else begin
      case (tx_state)
        st_pll_pd: begin
          timer <= timer + 1'b1;
          if (pll_done) tx_state <= st_tx_wait;
        end
        st_tx_wait: begin
          if (lane_status.pll_locked && !tx_busy) tx_state <= st_tx_ready;
        end
        default: begin
          if (ctrl.reset_tx_digital) tx_state <= st_tx_wait;  // digital stage only
        end
      endcase

      // rx writes the timer after tx so its restart wins
      case (rx_state)
        st_rx_idle: begin
          if (pll_done) begin
            rx_state <= st_rx_analog;
            timer    <= '0;
          end
        end
        st_rx_analog: begin
          if (timer != tw'(t_rx_analogreset - 1)) begin
            timer <= timer + 1'b1;
          end else if (!rx_busy) begin  // hold while calibrating
            rx_state <= st_rx_digital;
            timer    <= '0;
          end
        end
        st_rx_digital: begin
          if (ctrl.reset_rx_digital || !all_locked) begin
            timer <= '0;  // needs consecutive lock
          end else if (timer == tw'(t_rx_digitalreset - 1)) begin
            rx_state <= st_rx_ready;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: begin
          if (ctrl.reset_rx_digital || (!all_locked && !rx_manual)) begin
            rx_state <= st_rx_digital;  // lock loss only in auto mode
            timer    <= '0;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // final resets with register overrides
  ////////////////////////////////////////////////////////////
  assign tx_ready = (tx_state == st_tx_ready);
  assign rx_ready = (rx_state == st_rx_ready);

  assign resets.pll_powerdown   = (tx_state == st_pll_pd) | ctrl.pll_powerdown;
  assign resets.tx_digitalreset = {lanes{!tx_ready}} | ctrl.tx_digitalreset;
  assign resets.rx_analogreset  = {lanes{rx_state == st_rx_idle || rx_state == st_rx_analog}} |
                                  ctrl.rx_analogreset;
  assign resets.rx_digitalreset = {lanes{!rx_ready}} | ctrl.rx_digitalreset;

endmodule

`default_nettype wire

/* src/xaui_phy_ctrl.sv */
// xaui phy management and reset top
`default_nettype none

module xaui_phy_ctrl #(
  parameter int t_pll_powerdown   = 100,  // cycles of phy_mgmt_clk
  parameter int t_rx_analogreset  = 8,
  parameter int t_rx_digitalreset = 400
) (
  input  wire logic                          phy_mgmt_clk,
  input  wire logic                          embedded_reset,
  input  wire xaui_regs_pkg::mgmt_req_t      mgmt_req,
  output xaui_regs_pkg::mgmt_rsp_t           mgmt_rsp,
  input  wire xaui_lane_pkg::lane_status_t   lane_status,
  input  wire xaui_lane_pkg::pcs_status_t    pcs_status,
  output xaui_lane_pkg::reset_out_t          resets,
  output logic                               tx_ready,
  output logic                               rx_ready,
  output logic [xaui_lane_pkg::lanes-1:0]    loopback_serial,
  output logic [xaui_lane_pkg::lanes-1:0]    set_locktoref,
  output logic [xaui_lane_pkg::lanes-1:0]    set_locktodata,
  output logic                               r_tx_digitalreset,
  output logic                               r_rx_digitalreset
);

  xaui_regs_pkg::slave_req_t chan_req;  // to channel block
  xaui_regs_pkg::slave_req_t pcs_req;   // to pcs block
  logic [31:0]               chan_readdata;
  logic [31:0]               pcs_readdata;
  xaui_lane_pkg::csr_ctrl_t  ctrl;      // channel regs to sequencer

  ////////////////////////////////////////////////////////////
  // management decode
  ////////////////////////////////////////////////////////////
  mgmt_decoder u_decoder (
    .phy_mgmt_clk  (phy_mgmt_clk),
    .embedded_reset(embedded_reset),
    .mgmt_req      (mgmt_req),
    .chan_readdata (chan_readdata),
    .pcs_readdata  (pcs_readdata),
    .mgmt_rsp      (mgmt_rsp),
    .chan_req      (chan_req),
    .pcs_req       (pcs_req)
  );

  ////////////////////////////////////////////////////////////
  // register blocks
  ////////////////////////////////////////////////////////////
  chan_csr u_chan_csr (
    .phy_mgmt_clk  (phy_mgmt_clk),
    .embedded_reset(embedded_reset),
    .req           (chan_req),
    .lane_status   (lane_status),
    .tx_ready      (tx_ready),   // readback only
    .rx_ready      (rx_ready),
    .readdata      (chan_readdata),
    .ctrl          (ctrl)
  );

  pcs_csr u_pcs_csr (
    .phy_mgmt_clk     (phy_mgmt_clk),
    .embedded_reset   (embedded_reset),
    .req              (pcs_req),
    .pcs_status       (pcs_status),
    .readdata         (pcs_readdata),
    .r_tx_digitalreset(r_tx_digitalreset),
    .r_rx_digitalreset(r_rx_digitalreset)
  );

  ////////////////////////////////////////////////////////////
  // embedded reset sequencer
  ////////////////////////////////////////////////////////////
  reset_sequencer #(
    .t_pll_powerdown  (t_pll_powerdown),
    .t_rx_analogreset (t_rx_analogreset),
    .t_rx_digitalreset(t_rx_digitalreset)
  ) u_reset_seq (
    .phy_mgmt_clk  (phy_mgmt_clk),
    .embedded_reset(embedded_reset),
    .ctrl          (ctrl),
    .lane_status   (lane_status),
    .resets        (resets),
    .tx_ready      (tx_ready),
    .rx_ready      (rx_ready)
  );

  assign loopback_serial = ctrl.loopback_serial;  // straight to the pma
  assign set_locktoref   = ctrl.set_locktoref;
  assign set_locktodata  = ctrl.set_locktodata;

endmodule

`default_nettype wire

/* tb/tb_xaui_phy_ctrl.sv */
// xaui phy control testbench
`default_nettype none

module tb_xaui_phy_ctrl;

  localparam int half_period  = 10;
  localparam int bus_timeout  = 16;   // cycles for one bus transfer
  localparam int wait_timeout = 200;  // cycles for a ready flag change

  logic                            phy_mgmt_clk = 1'b0;
  logic                            embedded_reset;
  xaui_regs_pkg::mgmt_req_t        mgmt_req;
  xaui_regs_pkg::mgmt_rsp_t        mgmt_rsp;
  xaui_lane_pkg::lane_status_t     lane_status;
  xaui_lane_pkg::pcs_status_t      pcs_status;
  xaui_lane_pkg::reset_out_t       resets;
  logic                            tx_ready;
  logic                            rx_ready;
  logic [xaui_lane_pkg::lanes-1:0] loopback_serial;
  logic [xaui_lane_pkg::lanes-1:0] set_locktoref;
  logic [xaui_lane_pkg::lanes-1:0] set_locktodata;
  logic                            r_tx_digitalreset;
  logic                            r_rx_digitalreset;

  int errors;
  int timeouts;

  xaui_phy_ctrl #(
    .t_pll_powerdown  (8),
    .t_rx_analogreset (4),
    .t_rx_digitalreset(16)
  ) uut (
    .phy_mgmt_clk     (phy_mgmt_clk),
    .embedded_reset   (embedded_reset),
    .mgmt_req         (mgmt_req),
    .mgmt_rsp         (mgmt_rsp),
    .lane_status      (lane_status),
    .pcs_status       (pcs_status),
    .resets           (resets),
    .tx_ready         (tx_ready),
    .rx_ready         (rx_ready),
    .loopback_serial  (loopback_serial),
    .set_locktoref    (set_locktoref),
    .set_locktodata   (set_locktodata),
    .r_tx_digitalreset(r_tx_digitalreset),
    .r_rx_digitalreset(r_rx_digitalreset)
  );

  initial begin
    forever #half_period phy_mgmt_clk = ~phy_mgmt_clk;  // period 20
  end

  ////////////////////////////////////////////////////////////
  // compare and bus tasks
  ////////////////////////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    int   guard;
    int   waits;
    logic done;
    guard = 0;
    waits = 0;
    done  = 1'b0;
    @(negedge phy_mgmt_clk);
    mgmt_req.address   = addr;
    mgmt_req.read      = 1'b0;
    mgmt_req.write     = 1'b1;
    mgmt_req.writedata = data;
    while (!done && guard < bus_timeout) begin
      #1;  // mid cycle, response settled
      guard++;
      if (mgmt_rsp.waitrequest) waits++;
      else done = 1'b1;
      @(posedge phy_mgmt_clk);  // transfer edge
      if (!done) @(negedge phy_mgmt_clk);
    end
    if (!done) begin
      timeouts++;
      $display("timeout: write to address %h was never accepted", addr);
    end
    check($sformatf("waitrequest cycles, write %h", addr), waits, 0);  // writes never wait
    @(negedge phy_mgmt_clk);
    mgmt_req.write = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, input logic [31:0] expected);
    int          guard;
    int          waits;
    logic        done;
    logic [31:0] data;
    guard = 0;
    waits = 0;
    done  = 1'b0;
    data  = 'x;
    @(negedge phy_mgmt_clk);
    mgmt_req.address = addr;
    mgmt_req.read    = 1'b1;
    mgmt_req.write   = 1'b0;
    while (!done && guard < bus_timeout) begin
      #1;  // mid cycle, response settled
      guard++;
      if (mgmt_rsp.waitrequest) begin
        waits++;
      end else begin
        data = mgmt_rsp.readdata;  // valid with waitrequest low
        done = 1'b1;
      end
      @(posedge phy_mgmt_clk);
      if (!done) @(negedge phy_mgmt_clk);
    end
    if (!done) begin
      timeouts++;
      $display("timeout: read of address %h never completed", addr);
    end
    check($sformatf("waitrequest cycles, read %h", addr), waits, 1);
    check($sformatf("readdata at %h", addr), data, expected);
    @(negedge phy_mgmt_clk);
    mgmt_req.read = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // status drive and output checks
  ////////////////////////////////////////////////////////////
  task automatic pulse_pcs(input logic [31:0] value);
    @(negedge phy_mgmt_clk);
    pcs_status = value[$bits(pcs_status)-1:0];
    @(negedge phy_mgmt_clk);
    pcs_status.rx_errdetect = '0;  // errors last one cycle
    pcs_status.rx_disperr   = '0;  // sync status stays
  endtask

  task automatic wait_ready(input logic tx_exp, input logic rx_exp);
    int   guard;
    logic seen;
    guard = 0;
    seen  = 1'b0;
    while (!seen && guard < wait_timeout) begin
      @(negedge phy_mgmt_clk);  // mid cycle, flags settled
      guard++;
      seen = (tx_ready == tx_exp) && (rx_ready == rx_exp);
    end
    if (!seen) begin
      timeouts++;
      $display("timeout: tx_ready and rx_ready never became %b and %b", tx_exp, rx_exp);
    end
    check("tx_ready", 32'(tx_ready), 32'(tx_exp));
    check("rx_ready", 32'(rx_ready), 32'(rx_exp));
  endtask

  task automatic idle(input logic [31:0] cycles);
    for (int i = 0; i < int'(cycles); i++) begin
      @(negedge phy_mgmt_clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // cases file interpreter
  ////////////////////////////////////////////////////////////
  task automatic run_cases();
    int               fd;
    int               code;
    int               nf;
    logic [7:0]       cmd;   // command letter
    logic [31:0]      a;
    logic [31:0]      b;
    logic [8*160-1:0] rest;  // remainder of a comment line
    logic             more;
    fd = $fopen("tb/xaui_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the cases file tb/xaui_cases.txt");
    end else begin
      more = 1'b1;
      while (more) begin
        a    = '0;
        b    = '0;
        code = $fscanf(fd, "%s", cmd);
        if (code != 1) begin
          more = 1'b0;  // end of file
        end else if (cmd == "#") begin
          code = $fgets(rest, fd);
        end else begin
          if (cmd == "W" || cmd == "R" || cmd == "T") begin
            nf   = 2;
            code = $fscanf(fd, "%h %h", a, b);
          end else begin
            nf   = 1;
            code = $fscanf(fd, "%h", a);
          end
          if (code != nf) begin
            errors++;
            $display("a line of the cases file for command %c has missing fields", cmd);
            more = 1'b0;
          end else begin
            case (cmd)
              "W": bus_write(a[7:0], b);
              "R": bus_read(a[7:0], b);
              "S": begin
                @(negedge phy_mgmt_clk);
                lane_status = a[$bits(lane_status)-1:0];
              end
              "P": pulse_pcs(a);
              "T": wait_ready(a[0], b[0]);
              "O": begin
                @(negedge phy_mgmt_clk);
                check("resets", 32'(resets), a);
              end
              "L": begin
                @(negedge phy_mgmt_clk);
                check("pcs resets and lane controls",
                      32'({r_rx_digitalreset, r_tx_digitalreset, loopback_serial,
                           set_locktoref, set_locktodata}), a);
              end
              "I": idle(a);
              default: begin
                errors++;
                $display("unknown command %c in the cases file", cmd);
                more = 1'b0;
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    errors         = 0;
    timeouts       = 0;
    embedded_reset = 1'b1;
    mgmt_req       = '0;
    lane_status    = '0;
    pcs_status     = '0;
    repeat (3) @(negedge phy_mgmt_clk);  // three rising edges in reset
    embedded_reset = 1'b0;
    run_cases();
    idle(2);
    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/xaui_cases.txt */
# hex fields: W addr data | R addr expected | S lane_status | P pcs_status | T tx rx
# O resets | L {r_rx, r_tx, loopback, locktoref, locktodata} | I idle cycles
O 1fff
T 0 0
S 200f
T 1 0
T 1 1
O 0000
L 0000
R 42 3
# channel registers
W 44 1
O 1000
R 44 1
W 44 0
W 45 a
R 45 a
O 0a00
W 45 0
W 46 5
R 46 5
W 46 0
W 48 3
W 49 c
W 4a 6
R 48 3
R 49 c
R 4a 6
L 03c6
W 48 0
W 49 0
W 4a 0
R 41 1
R 4b f
W 4b 0
R 4b f
R 43 0
R 10 ffffffff
R c0 ffffffff
W 10 5
R 9f 0
# pcs registers
P 002184
R 82 21
R 83 84
W 82 1
R 82 20
R 83 84
W 83 ff
R 83 0
P 3c0000
R 81 3c
P 000000
R 81 0
W 80 3
R 80 3
L 3000
W 80 0
# lane override and lock loss
W 47 4
O 0004
T 1 1
W 47 0
S 200d
T 1 0
O 000f
S 200f
T 1 1
W 4a f
S 200d
I 20
T 1 1
S 200f
W 4a 0
# restarts
W 42 1
T 0 0
O 1fff
T 1 1
O 0000
W 42 4
T 1 0
T 1 1

/* tb.f */
src/xaui_regs_pkg.sv
src/xaui_lane_pkg.sv
src/mgmt_decoder.sv
src/chan_csr.sv
src/pcs_csr.sv
src/reset_sequencer.sv
src/xaui_phy_ctrl.sv
tb/tb_xaui_phy_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the xaui phy control testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_xaui_phy_ctrl \
  -Mdir obj_dir -o sim_tb -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "testbench reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0
